//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_issue_stage
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^>>> PASS$$" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/issue_defines.svh
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// ==========================================================================
// issue stage sizes.
// ==========================================================================

// datapath.
`define ISS_WORD_W    32
`define ISS_IMM_W     16

// physical register file.
`define ISS_PREGS     32
`define ISS_TAG_W     5

// queue depths, one per unit.
`define ISS_ALU_QLEN  4
`define ISS_MEM_QLEN  4

`endif

//--- src/issue_intf.sv
`include "issue_defines.svh"

// dispatch write bundle, shared by both queues.
interface queue_write_if import issue_pkg::*; ();
    logic                  valid;
    unit_e                 unit;
    tag_t                  dst;
    src_t                  src1;
    src_t                  src2;
    op_ctl_u               ctl;
    logic [`ISS_IMM_W-1:0] imm;

    modport capture (
        output valid, unit, dst, src1, src2, ctl, imm
    );

    modport queue (
        input valid, unit, dst, src1, src2, ctl, imm
    );
endinterface

// one selected entry per queue, take comes back from the issue register.
interface issue_pick_if import issue_pkg::*; ();
    logic                  valid;
    tag_t                  dst;
    word_t                 a;
    word_t                 b;
    op_ctl_u               ctl;
    logic [`ISS_IMM_W-1:0] imm;
    logic                  take;

    modport queue (
        output valid, dst, a, b, ctl, imm,
        input  take
    );

    modport merge (
        input  valid, dst, a, b, ctl, imm,
        output take
    );
endinterface

//--- src/issue_pkg.sv
`include "issue_defines.svh"

package issue_pkg;

    typedef logic [`ISS_WORD_W-1:0] word_t;
    typedef logic [`ISS_TAG_W-1:0]  tag_t;

    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MEM = 1'b1
    } unit_e;

    // ======================================================================
    // control word, decoded per unit.
    // ======================================================================

    typedef struct packed {
        logic [2:0] spare;
        logic       use_imm;  // src2 replaced by imm.
        logic [3:0] alu_op;
    } alu_ctl_t;

    typedef struct packed {
        logic [3:0] spare;
        logic       sign_ext;
        logic [1:0] size;     // byte, half, word.
        logic       is_store;
    } mem_ctl_t;

    typedef union packed {
        alu_ctl_t alu;
        mem_ctl_t mem;
    } op_ctl_u;

    // ======================================================================
    // queue storage.
    // ======================================================================

    typedef struct packed {
        logic  ready;
        tag_t  tag;
        word_t data;
    } src_t;

    typedef struct packed {
        logic                  valid;
        tag_t                  dst;
        src_t                  src1;
        src_t                  src2;
        op_ctl_u               ctl;
        logic [`ISS_IMM_W-1:0] imm;
    } iq_entry_t;

endpackage

//--- src/issue_queue.sv
module issue_queue import issue_pkg::*; #(
    parameter int    QUEUE_LEN  = 4,
    parameter unit_e QUEUE_UNIT = UNIT_ALU
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush,
    queue_write_if.queue  wr,
    input  logic          wb_valid,
    input  tag_t          wb_tag,
    input  word_t         wb_data,
    input  logic          hold,
    issue_pick_if.queue   pick,
    output logic          full
);

    localparam int IDX_W = (QUEUE_LEN > 1) ? $clog2(QUEUE_LEN) : 1;

    // entries are kept compacted, slot 0 is the oldest.
    iq_entry_t q   [QUEUE_LEN];
    iq_entry_t nxt [QUEUE_LEN];

    iq_entry_t            new_entry;
    logic                 wr_hit;
    logic [QUEUE_LEN-1:0] valid_vec;
    logic [IDX_W-1:0]     sel_idx;
    logic                 sel_found;

    always_comb begin
        for (int i = 0; i < QUEUE_LEN; i++) begin
            valid_vec[i] = q[i].valid;
        end
    end

    assign full   = &valid_vec;
    assign wr_hit = wr.valid && (wr.unit == QUEUE_UNIT) && !full;

    assign new_entry.valid = 1'b1;
    assign new_entry.dst   = wr.dst;
    assign new_entry.src1  = wr.src1;
    assign new_entry.src2  = wr.src2;
    assign new_entry.ctl   = wr.ctl;
    assign new_entry.imm   = wr.imm;

    // ======================================================================
    // select oldest ready entry.
    // ======================================================================

    always_comb begin
        sel_idx   = '0;
        sel_found = 1'b0;
        for (int i = QUEUE_LEN - 1; i >= 0; i--) begin  // lowest slot wins.
            if (q[i].valid && q[i].src1.ready && q[i].src2.ready) begin
                sel_idx   = IDX_W'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign pick.valid = sel_found && !hold;
    assign pick.dst   = q[sel_idx].dst;
    assign pick.a     = q[sel_idx].src1.data;
    assign pick.b     = q[sel_idx].src2.data;
    assign pick.ctl   = q[sel_idx].ctl;
    assign pick.imm   = q[sel_idx].imm;

    // ======================================================================
    // next state: wakeup, remove, insert, flush.
    // ======================================================================

    always_comb begin
        logic placed;
        nxt = q;

        if (wb_valid) begin
            for (int i = 0; i < QUEUE_LEN; i++) begin
                if (!nxt[i].src1.ready && nxt[i].src1.tag == wb_tag) begin
                    nxt[i].src1.ready = 1'b1;
                    nxt[i].src1.data  = wb_data;
                end
                if (!nxt[i].src2.ready && nxt[i].src2.tag == wb_tag) begin
                    nxt[i].src2.ready = 1'b1;
                    nxt[i].src2.data  = wb_data;
                end
            end
        end

        // close the gap left by the issued entry.
        if (pick.take) begin
            for (int i = 0; i < QUEUE_LEN - 1; i++) begin
                if (i >= int'(sel_idx)) begin
                    nxt[i] = nxt[i+1];
                end
            end
            nxt[QUEUE_LEN-1].valid = 1'b0;
        end

        placed = 1'b0;
        if (wr_hit) begin
            for (int i = 0; i < QUEUE_LEN; i++) begin
                if (!placed && !nxt[i].valid) begin
                    nxt[i] = new_entry;  // first free slot is the youngest.
                    placed = 1'b1;
                end
            end
        end

        if (flush) begin
            for (int i = 0; i < QUEUE_LEN; i++) begin
                nxt[i].valid = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < QUEUE_LEN; i++) begin
                q[i] <= '0;
            end
        end else begin
            q <= nxt;
        end
    end

endmodule

//--- src/issue_reg.sv
`include "issue_defines.svh"

module issue_reg import issue_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  mem_done,
    issue_pick_if.merge           alu_pick,
    issue_pick_if.merge           mem_pick,
    output logic                  mem_busy,
    output logic                  alu_valid,
    output logic                  mem_valid,
    output tag_t                  alu_dst,
    output tag_t                  mem_dst,
    output word_t                 alu_a,
    output word_t                 alu_b,
    output word_t                 mem_base,
    output word_t                 mem_data,
    output op_ctl_u               alu_ctl,
    output op_ctl_u               mem_ctl,
    output logic [`ISS_IMM_W-1:0] alu_imm,
    output logic [`ISS_IMM_W-1:0] mem_imm
);

    // a pick is taken whenever it is offered, except under flush.
    assign alu_pick.take = alu_pick.valid && !flush;
    assign mem_pick.take = mem_pick.valid && !flush;

    // ======================================================================
    // issue valids and load tracking.
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
            mem_valid <= 1'b0;
            mem_busy  <= 1'b0;
        end else begin
            alu_valid <= alu_pick.take;
            mem_valid <= mem_pick.take;
            if (flush) begin
                mem_busy <= 1'b0;
            end else if (mem_pick.take && !mem_pick.ctl.mem.is_store) begin
                mem_busy <= 1'b1;  // load now outstanding.
            end else if (mem_done) begin
                mem_busy <= 1'b0;
            end
        end
    end

    // payload only moves with a taken pick.
    always_ff @(posedge clk) begin
        if (alu_pick.take) begin
            alu_dst <= alu_pick.dst;
            alu_a   <= alu_pick.a;
            alu_b   <= alu_pick.b;
            alu_ctl <= alu_pick.ctl;
            alu_imm <= alu_pick.imm;
        end
        if (mem_pick.take) begin
            mem_dst  <= mem_pick.dst;
            mem_base <= mem_pick.a;
            mem_data <= mem_pick.b;   // store data.
            mem_ctl  <= mem_pick.ctl;
            mem_imm  <= mem_pick.imm;
        end
    end

endmodule

//--- src/issue_stage.sv
`include "issue_defines.svh"

module issue_stage import issue_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  in_valid,
    input  unit_e                 in_unit,
    input  tag_t                  in_dst,
    input  tag_t                  in_src1,
    input  tag_t                  in_src2,
    input  op_ctl_u               in_ctl,
    input  logic [`ISS_IMM_W-1:0] in_imm,
    input  logic                  wb_valid,
    input  tag_t                  wb_tag,
    input  word_t                 wb_data,
    input  logic                  mem_done,
    output logic                  alu_valid,
    output tag_t                  alu_dst,
    output word_t                 alu_a,
    output word_t                 alu_b,
    output op_ctl_u               alu_ctl,
    output logic [`ISS_IMM_W-1:0] alu_imm,
    output logic                  mem_valid,
    output tag_t                  mem_dst,
    output word_t                 mem_base,
    output word_t                 mem_data,
    output op_ctl_u               mem_ctl,
    output logic [`ISS_IMM_W-1:0] mem_imm,
    output logic                  alu_full,
    output logic                  mem_full,
    output logic                  mem_busy
);

    queue_write_if wr_bus ();
    issue_pick_if  alu_pick_bus ();
    issue_pick_if  mem_pick_bus ();

    operand_capture capture_i (
        .clk, .rst_n,
        .in_valid, .in_unit, .in_dst, .in_src1, .in_src2, .in_ctl, .in_imm,
        .wb_valid, .wb_tag, .wb_data,
        .wr(wr_bus.capture)
    );

    issue_queue #(.QUEUE_LEN(`ISS_ALU_QLEN), .QUEUE_UNIT(UNIT_ALU)) alu_queue (
        .clk, .rst_n, .flush,
        .wr(wr_bus.queue),
        .wb_valid, .wb_tag, .wb_data,
        .hold(1'b0),                 // alu side never stalls.
        .pick(alu_pick_bus.queue),
        .full(alu_full)
    );

    issue_queue #(.QUEUE_LEN(`ISS_MEM_QLEN), .QUEUE_UNIT(UNIT_MEM)) mem_queue (
        .clk, .rst_n, .flush,
        .wr(wr_bus.queue),
        .wb_valid, .wb_tag, .wb_data,
        .hold(mem_busy),
        .pick(mem_pick_bus.queue),
        .full(mem_full)
    );

    issue_reg issue_reg_i (
        .clk, .rst_n, .flush, .mem_done,
        .alu_pick(alu_pick_bus.merge),
        .mem_pick(mem_pick_bus.merge),
        .mem_busy,
        .alu_valid, .mem_valid,
        .alu_dst, .mem_dst,
        .alu_a, .alu_b, .mem_base, .mem_data,
        .alu_ctl, .mem_ctl,
        .alu_imm, .mem_imm
    );

endmodule

//--- src/operand_capture.sv
`include "issue_defines.svh"

module operand_capture import issue_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  unit_e                 in_unit,
    input  tag_t                  in_dst,
    input  tag_t                  in_src1,
    input  tag_t                  in_src2,
    input  op_ctl_u               in_ctl,
    input  logic [`ISS_IMM_W-1:0] in_imm,
    input  logic                  wb_valid,
    input  tag_t                  wb_tag,
    input  word_t                 wb_data,
    queue_write_if.capture        wr
);

    logic [`ISS_PREGS-1:0] reg_ready;
    word_t                 reg_data [`ISS_PREGS];

    src_t rd1;
    src_t rd2;
    logic src2_needed;

    // register file read with writeback bypass.
    function automatic src_t read_src(input tag_t tag);
        src_t s;
        s.tag = tag;
        if (wb_valid && wb_tag == tag) begin
            s.ready = 1'b1;
            s.data  = wb_data;
        end else begin
            s.ready = reg_ready[tag];
            s.data  = reg_data[tag];
        end
        return s;
    endfunction

    assign rd1 = read_src(in_src1);
    assign rd2 = read_src(in_src2);

    // alu ops with an immediate and loads never wait on src2.
    always_comb begin
        if (in_unit == UNIT_ALU) begin
            src2_needed = ~in_ctl.alu.use_imm;
        end else begin
            src2_needed = in_ctl.mem.is_store;
        end
    end

    // ======================================================================
    // write bundle.
    // ======================================================================

    assign wr.valid      = in_valid;
    assign wr.unit       = in_unit;
    assign wr.dst        = in_dst;
    assign wr.src1       = rd1;
    assign wr.src2.tag   = rd2.tag;
    assign wr.src2.data  = rd2.data;
    assign wr.src2.ready = rd2.ready | ~src2_needed;
    assign wr.ctl        = in_ctl;
    assign wr.imm        = in_imm;

    // ======================================================================
    // register file update.
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_ready <= '0;
            for (int i = 0; i < `ISS_PREGS; i++) begin
                reg_data[i] <= '0;
            end
        end else begin
            if (wb_valid) begin
                reg_ready[wb_tag] <= 1'b1;
                reg_data[wb_tag]  <= wb_data;
            end
            if (in_valid) begin
                reg_ready[in_dst] <= 1'b0;  // new producer wins over writeback.
            end
        end
    end

endmodule

//--- tb.f
+incdir+src
src/issue_pkg.sv
src/issue_intf.sv
src/operand_capture.sv
src/issue_queue.sv
src/issue_reg.sv
src/issue_stage.sv
test/tb_issue_stage.sv

//--- test/tb_issue_stage.sv
`include "issue_defines.svh"

module tb_issue_stage import issue_pkg::*; ();

    localparam int CLK_PERIOD    = 8;
    localparam int TEST_CYCLES   = 70;  // five tests plus reset.
    localparam int MARGIN_CYCLES = 50;

    logic                  clk;
    logic                  rst_n;
    logic                  flush;
    logic                  in_valid;
    unit_e                 in_unit;
    tag_t                  in_dst;
    tag_t                  in_src1;
    tag_t                  in_src2;
    op_ctl_u               in_ctl;
    logic [`ISS_IMM_W-1:0] in_imm;
    logic                  wb_valid;
    tag_t                  wb_tag;
    word_t                 wb_data;
    logic                  mem_done;
    logic                  alu_valid;
    tag_t                  alu_dst;
    word_t                 alu_a;
    word_t                 alu_b;
    op_ctl_u               alu_ctl;
    logic [`ISS_IMM_W-1:0] alu_imm;
    logic                  mem_valid;
    tag_t                  mem_dst;
    word_t                 mem_base;
    word_t                 mem_data;
    op_ctl_u               mem_ctl;
    logic [`ISS_IMM_W-1:0] mem_imm;
    logic                  alu_full;
    logic                  mem_full;
    logic                  mem_busy;

    word_t rf_model [`ISS_PREGS];  // last value written back per tag.

    issue_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        $display("watchdog expired, the tests did not finish in time");
        $display(">>> FAIL");
        $fatal(1, "watchdog");
    end

    // ======================================================================
    // helpers and compare tasks.
    // ======================================================================

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ctl(input string name, input op_ctl_u got, input op_ctl_u exp);
        if (got !== exp) begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_imm(input string name, input logic [`ISS_IMM_W-1:0] got,
                             input logic [`ISS_IMM_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic word_t rand_word();
        return word_t'($urandom);
    endfunction

    function automatic logic [`ISS_IMM_W-1:0] rand_imm();
        return `ISS_IMM_W'($urandom);
    endfunction

    function automatic op_ctl_u make_alu_ctl(input logic [3:0] op, input logic use_imm);
        op_ctl_u c;
        c             = '0;
        c.alu.alu_op  = op;
        c.alu.use_imm = use_imm;
        return c;
    endfunction

    function automatic op_ctl_u make_mem_ctl(input logic is_store, input logic [1:0] size);
        op_ctl_u c;
        c              = '0;
        c.mem.is_store = is_store;
        c.mem.size     = size;
        return c;
    endfunction

    // all drive tasks start and end on a falling edge.
    task automatic write_back(input tag_t tag, input word_t data);
        wb_valid      = 1'b1;
        wb_tag        = tag;
        wb_data       = data;
        rf_model[tag] = data;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic dispatch(input unit_e unit, input tag_t dst, input tag_t s1, input tag_t s2,
                            input op_ctl_u ctl, input logic [`ISS_IMM_W-1:0] imm);
        in_valid = 1'b1;
        in_unit  = unit;
        in_dst   = dst;
        in_src1  = s1;
        in_src2  = s2;
        in_ctl   = ctl;
        in_imm   = imm;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic pulse_mem_done();
        mem_done = 1'b1;
        @(negedge clk);
        mem_done = 1'b0;
    endtask

    task automatic wait_mem_issue(input int max_cycles);
        int n;
        n = 0;
        while (mem_valid !== 1'b1 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (mem_valid !== 1'b1) begin
            $display("no memory op was issued within %0d cycles", max_cycles);
            abort_run();
        end
    endtask

    task automatic check_alu_issue(input tag_t dst, input word_t a, input word_t b,
                                   input op_ctl_u ctl, input logic [`ISS_IMM_W-1:0] imm);
        check_bit("alu_valid", alu_valid, 1'b1);
        check_tag("alu_dst", alu_dst, dst);
        check_word("alu_a", alu_a, a);
        check_word("alu_b", alu_b, b);
        check_ctl("alu_ctl", alu_ctl, ctl);
        check_imm("alu_imm", alu_imm, imm);
    endtask

    task automatic check_mem_issue(input tag_t dst, input word_t base, input word_t data,
                                   input op_ctl_u ctl, input logic [`ISS_IMM_W-1:0] imm);
        check_bit("mem_valid", mem_valid, 1'b1);
        check_tag("mem_dst", mem_dst, dst);
        check_word("mem_base", mem_base, base);
        check_word("mem_data", mem_data, data);
        check_ctl("mem_ctl", mem_ctl, ctl);
        check_imm("mem_imm", mem_imm, imm);
    endtask

    // ======================================================================
    // directed tests.
    // ======================================================================

    task automatic test_ready_alu();
        op_ctl_u               ctl;
        logic [`ISS_IMM_W-1:0] imm;
        ctl = make_alu_ctl(4'h3, 1'b0);
        imm = rand_imm();
        write_back(5'd1, rand_word());
        write_back(5'd2, rand_word());
        dispatch(UNIT_ALU, 5'd10, 5'd1, 5'd2, ctl, imm);
        check_bit("alu_valid", alu_valid, 1'b0);
        @(negedge clk);
        check_alu_issue(5'd10, rf_model[1], rf_model[2], ctl, imm);
        @(negedge clk);
        check_bit("alu_valid", alu_valid, 1'b0);  // issued once only.
    endtask

    task automatic test_wakeup();
        op_ctl_u ctl;
        op_ctl_u ctl_imm;
        ctl     = make_alu_ctl(4'h5, 1'b0);
        ctl_imm = make_alu_ctl(4'h1, 1'b1);
        dispatch(UNIT_ALU, 5'd11, 5'd1, 5'd5, ctl, 16'h0011);
        repeat (3) begin
            check_bit("alu_valid", alu_valid, 1'b0);
            @(negedge clk);
        end
        write_back(5'd5, rand_word());
        check_bit("alu_valid", alu_valid, 1'b0);
        @(negedge clk);
        check_alu_issue(5'd11, rf_model[1], rf_model[5], ctl, 16'h0011);
        // src2 of tag 6 is never written.
        dispatch(UNIT_ALU, 5'd12, 5'd2, 5'd6, ctl_imm, 16'h0abc);
        check_bit("alu_valid", alu_valid, 1'b0);
        @(negedge clk);
        check_alu_issue(5'd12, rf_model[2], rf_model[6], ctl_imm, 16'h0abc);
    endtask

    task automatic test_order_parallel();
        op_ctl_u ctl;
        op_ctl_u st;
        ctl = make_alu_ctl(4'h2, 1'b0);
        st  = make_mem_ctl(1'b1, 2'd2);
        dispatch(UNIT_ALU, 5'd13, 5'd7, 5'd1, ctl, 16'h0013);
        dispatch(UNIT_ALU, 5'd14, 5'd7, 5'd2, ctl, 16'h0014);
        dispatch(UNIT_MEM, 5'd16, 5'd7, 5'd2, st, 16'h0016);
        dispatch(UNIT_ALU, 5'd15, 5'd1, 5'd7, ctl, 16'h0015);
        write_back(5'd7, rand_word());  // wakes all four at once.
        check_bit("alu_valid", alu_valid, 1'b0);
        check_bit("mem_valid", mem_valid, 1'b0);
        @(negedge clk);
        check_alu_issue(5'd13, rf_model[7], rf_model[1], ctl, 16'h0013);
        check_mem_issue(5'd16, rf_model[7], rf_model[2], st, 16'h0016);
        check_bit("mem_busy", mem_busy, 1'b0);
        @(negedge clk);
        check_alu_issue(5'd14, rf_model[7], rf_model[2], ctl, 16'h0014);
        check_bit("mem_valid", mem_valid, 1'b0);
        @(negedge clk);
        check_alu_issue(5'd15, rf_model[1], rf_model[7], ctl, 16'h0015);
        @(negedge clk);
        check_bit("alu_valid", alu_valid, 1'b0);
    endtask

    task automatic test_load_block();
        op_ctl_u st;
        op_ctl_u ld;
        st = make_mem_ctl(1'b1, 2'd2);
        ld = make_mem_ctl(1'b0, 2'd2);
        dispatch(UNIT_MEM, 5'd17, 5'd1, 5'd2, st, 16'h0017);
        @(negedge clk);
        check_mem_issue(5'd17, rf_model[1], rf_model[2], st, 16'h0017);
        check_bit("mem_busy", mem_busy, 1'b0);
        dispatch(UNIT_MEM, 5'd18, 5'd1, 5'd0, ld, 16'h0018);
        dispatch(UNIT_MEM, 5'd19, 5'd2, 5'd0, ld, 16'h0019);
        check_mem_issue(5'd18, rf_model[1], rf_model[0], ld, 16'h0018);
        check_bit("mem_busy", mem_busy, 1'b1);
        repeat (3) begin
            @(negedge clk);
            check_bit("mem_valid", mem_valid, 1'b0);
            check_bit("mem_busy", mem_busy, 1'b1);
        end
        pulse_mem_done();
        check_bit("mem_busy", mem_busy, 1'b0);
        wait_mem_issue(4);
        check_mem_issue(5'd19, rf_model[2], rf_model[0], ld, 16'h0019);
        check_bit("mem_busy", mem_busy, 1'b1);
        pulse_mem_done();
        check_bit("mem_busy", mem_busy, 1'b0);
    endtask

    task automatic test_full_flush();
        op_ctl_u ctl;
        ctl = make_alu_ctl(4'h7, 1'b0);
        for (int i = 0; i < `ISS_ALU_QLEN; i++) begin
            dispatch(UNIT_ALU, tag_t'(20 + i), 5'd8, 5'd1, ctl, 16'h0020);
            check_bit("alu_full", alu_full, i == `ISS_ALU_QLEN - 1);
        end
        // a ready op would issue if the queue took it in.
        dispatch(UNIT_ALU, 5'd24, 5'd1, 5'd2, ctl, 16'h0024);
        repeat (3) begin
            check_bit("alu_valid", alu_valid, 1'b0);
            check_bit("alu_full", alu_full, 1'b1);
            @(negedge clk);
        end
        check_bit("mem_full", mem_full, 1'b0);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_bit("alu_full", alu_full, 1'b0);
        write_back(5'd8, rand_word());
        repeat (3) begin
            check_bit("alu_valid", alu_valid, 1'b0);
            @(negedge clk);
        end
    endtask

    // ======================================================================
    // main sequence.
    // ======================================================================

    initial begin
        void'($urandom(45074));
        rst_n    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_unit  = UNIT_ALU;
        in_dst   = '0;
        in_src1  = '0;
        in_src2  = '0;
        in_ctl   = '0;
        in_imm   = '0;
        wb_valid = 1'b0;
        wb_tag   = '0;
        wb_data  = '0;
        mem_done = 1'b0;
        for (int i = 0; i < `ISS_PREGS; i++) begin
            rf_model[i] = '0;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_ready_alu();
        test_wakeup();
        test_order_parallel();
        test_load_block();
        test_full_flush();

        $display(">>> PASS");
        $finish;
    end

endmodule
